//--- verilog/dcache_pkg.sv
// shared widths, wishbone request and response structs, address fields, state and command enums
`default_nettype none

package dcache_pkg;

	// ====================
	// sizes
	// ====================

	// byte address and data word widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// a line is four words, so the word offset sits in address bits [3:2]
	localparam int LINE_WORDS = 4;
	localparam int WORD_W = $clog2(LINE_WORDS);

	// the victim logic is a single bit, so the way count is fixed at two
	localparam int WAYS = 2;

	// address bits above the word offset, split later into tag and index
	localparam int LINE_ADR_W = ADDR_W - WORD_W - 2;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [DATA_W/8-1:0] sel_t;

	// ====================
	// wishbone classic
	// ====================

	// master to slave, held steady until the master samples ack
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		sel_t sel;
		addr_t adr;
		data_t dat;
	} wb_req_t;

	// slave to master, ack lasts one cycle per access
	typedef struct packed {
		logic ack;
		data_t dat;
	} wb_rsp_t;

	// byte address seen as line address, word in line and byte in word
	typedef struct packed {
		logic [LINE_ADR_W-1:0] line;
		logic [WORD_W-1:0] word;
		logic [1:0] boff;
	} addr_fields_t;

	// controller states
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WB_BEAT,
		FILL_BEAT,
		COMPLETE,
		BYPASS,
		RESPOND
	} ctrl_state_e;

	// opcodes from the controller to the way arrays
	typedef enum logic [2:0] {
		ARR_NONE,
		ARR_LOOKUP,
		ARR_FILL_WORD,
		ARR_STORE,
		ARR_SET_TAG,
		ARR_READ_VICTIM
	} array_cmd_e;

endpackage

`default_nettype wire

//--- verilog/line_beat_counter.sv
// beat counter for the four word transfers of a cache line
`timescale 1ns/1ps
`default_nettype none

module line_beat_counter (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic start_i,
	input  wire logic ack_i,
	output logic [dcache_pkg::WORD_W-1:0] idx_o,
	output logic last_o
);
	import dcache_pkg::*;

	logic [WORD_W-1:0] idx_q;

	// start wins over ack, so the end of a writeback can restart the count
	// for the fill in the same cycle as its final ack
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			idx_q <= '0;
		end else if (start_i) begin
			idx_q <= '0;
		end else if (ack_i) begin
			// wraps to zero after the last word
			idx_q <= idx_q + WORD_W'(1);
		end
	end

	// the index doubles as the word offset of the memory address
	assign idx_o = idx_q;

	// flags the final beat so the controller can leave the transfer state
	assign last_o = (idx_q == WORD_W'(LINE_WORDS - 1));

endmodule

`default_nettype wire

//--- verilog/dcache_ways.sv
// two-way tag, valid, dirty and data arrays with hit compare, victim choice, snoop and invalidate
`timescale 1ns/1ps
`default_nettype none

module dcache_ways #(
	parameter int SETS = 16,
	localparam int TAG_W = dcache_pkg::LINE_ADR_W - $clog2(SETS)
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire dcache_pkg::array_cmd_e cmd_i,
	input  wire dcache_pkg::addr_t addr_i,
	input  wire logic [dcache_pkg::WORD_W-1:0] word_i,
	input  wire dcache_pkg::data_t wdata_i,
	input  wire dcache_pkg::sel_t sel_i,
	output logic hit_o,
	output logic hit_way_o,
	output logic victim_dirty_o,
	output logic [TAG_W-1:0] victim_tag_o,
	output dcache_pkg::data_t rd_word_o,
	input  wire logic snoop_v_i,
	input  wire dcache_pkg::addr_t snoop_adr_i,
	input  wire logic inv_all_i
);
	import dcache_pkg::*;

	localparam int IDX_W = $clog2(SETS);

	// ====================
	// storage
	// ====================

	logic [TAG_W-1:0] tag_mem [WAYS][SETS];
	data_t data_mem [WAYS][SETS][LINE_WORDS];

	// valid and dirty are flops so that snoop and invalidate-all act at once
	logic [SETS-1:0] valid_q [WAYS];
	logic [SETS-1:0] dirty_q [WAYS];

	// round-robin pointer per set, names the victim when both ways are valid
	logic [SETS-1:0] rr_q;

	addr_fields_t req_f;
	addr_fields_t snp_f;
	logic [IDX_W-1:0] set_idx;
	logic [IDX_W-1:0] snp_idx;
	logic [TAG_W-1:0] req_tag;
	logic [TAG_W-1:0] snp_tag;
	logic [WAYS-1:0] way_hit;
	logic [WAYS-1:0] snp_hit;
	logic any_hit;
	logic victim;
	data_t merged;

	// ====================
	// compare and choose
	// ====================

	always_comb begin
		req_f = addr_i;
		snp_f = snoop_adr_i;
		set_idx = req_f.line[IDX_W-1:0];
		req_tag = req_f.line[LINE_ADR_W-1:IDX_W];
		snp_idx = snp_f.line[IDX_W-1:0];
		snp_tag = snp_f.line[LINE_ADR_W-1:IDX_W];

		// the snoop has its own tag read, separate from the request set
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = valid_q[w][set_idx] && (tag_mem[w][set_idx] == req_tag);
			snp_hit[w] = valid_q[w][snp_idx] && (tag_mem[w][snp_idx] == snp_tag);
		end
		any_hit = |way_hit;

		// an invalid way is taken first, way 0 before way 1
		if (!valid_q[0][set_idx]) begin
			victim = 1'b0;
		end else if (!valid_q[1][set_idx]) begin
			victim = 1'b1;
		end else begin
			victim = rr_q[set_idx];
		end

		// byte lane merge of the incoming word into the target word
		for (int b = 0; b < DATA_W / 8; b++) begin
			merged[8*b +: 8] = sel_i[b] ? wdata_i[8*b +: 8]
				: data_mem[hit_way_o][set_idx][word_i][8*b +: 8];
		end
	end

	// ====================
	// control state
	// ====================

	// hit_way_o holds the hit way after a hit and the victim after a miss,
	// so every later fill, store or victim read of this access goes there
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hit_o <= 1'b0;
			hit_way_o <= 1'b0;
			victim_dirty_o <= 1'b0;
			rr_q <= '0;
			for (int w = 0; w < WAYS; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
		end else begin
			case (cmd_i)
				ARR_LOOKUP: begin
					hit_o <= any_hit;
					hit_way_o <= any_hit ? way_hit[1] : victim;
					victim_dirty_o <= valid_q[victim][set_idx] && dirty_q[victim][set_idx];
				end
				ARR_STORE: begin
					dirty_q[hit_way_o][set_idx] <= 1'b1;
				end
				ARR_SET_TAG: begin
					// the refilled line becomes valid and clean only now
					valid_q[hit_way_o][set_idx] <= 1'b1;
					dirty_q[hit_way_o][set_idx] <= 1'b0;
					rr_q[set_idx] <= ~rr_q[set_idx];
				end
				default: begin
				end
			endcase

			// a snoop drops the matching line without any writeback
			for (int w = 0; w < WAYS; w++) begin
				if (snoop_v_i && snp_hit[w]) begin
					valid_q[w][snp_idx] <= 1'b0;
				end
			end

			// invalidate-all comes last and discards any dirty data
			if (inv_all_i) begin
				for (int w = 0; w < WAYS; w++) begin
					valid_q[w] <= '0;
				end
			end
		end
	end

	// ====================
	// arrays and read data
	// ====================

	always_ff @(posedge clk) begin
		case (cmd_i)
			ARR_LOOKUP: begin
				victim_tag_o <= tag_mem[victim][set_idx];
				rd_word_o <= data_mem[any_hit ? way_hit[1] : 1'b0][set_idx][word_i];
			end
			ARR_READ_VICTIM: begin
				rd_word_o <= data_mem[hit_way_o][set_idx][word_i];
			end
			ARR_FILL_WORD, ARR_STORE: begin
				data_mem[hit_way_o][set_idx][word_i] <= merged;
			end
			ARR_SET_TAG: begin
				tag_mem[hit_way_o][set_idx] <= req_tag;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
// cache controller FSM for lookup, writeback, refill, pass-through and cpu acknowledge
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
	parameter int SETS = 16,
	localparam int TAG_W = dcache_pkg::LINE_ADR_W - $clog2(SETS)
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire dcache_pkg::wb_req_t cpu_req_i,
	output dcache_pkg::wb_rsp_t cpu_rsp_o,
	output dcache_pkg::wb_req_t mem_req_o,
	input  wire dcache_pkg::wb_rsp_t mem_rsp_i,
	input  wire logic dce_i,
	output dcache_pkg::array_cmd_e arr_cmd_o,
	output logic [dcache_pkg::WORD_W-1:0] arr_word_o,
	output dcache_pkg::data_t arr_wdata_o,
	output dcache_pkg::sel_t arr_sel_o,
	output dcache_pkg::addr_t arr_tag_addr_o,
	input  wire logic hit_i,
	input  wire logic victim_dirty_i,
	input  wire logic [TAG_W-1:0] victim_tag_i,
	input  wire dcache_pkg::data_t rd_word_i,
	output logic beat_start_o,
	output logic beat_ack_o,
	input  wire logic [dcache_pkg::WORD_W-1:0] beat_idx_i,
	input  wire logic last_beat_i
);
	import dcache_pkg::*;

	localparam int IDX_W = $clog2(SETS);

	ctrl_state_e state_q;
	ctrl_state_e state_d;

	// sub-step inside WB_BEAT, FILL_BEAT and COMPLETE
	// in the beat states 0 is the gap cycle between bus cycles and 1 the bus cycle
	logic phase_q;
	logic phase_d;

	data_t rsp_dat_q;
	data_t rsp_dat_d;
	logic rsp_load;
	logic cpu_req;
	addr_fields_t req_f;
	addr_fields_t fill_f;
	addr_fields_t wb_f;

	// ====================
	// memory addresses
	// ====================

	always_comb begin
		cpu_req = cpu_req_i.cyc && cpu_req_i.stb;
		req_f = cpu_req_i.adr;
		// the fill walks the words of the requested line
		fill_f = req_f;
		fill_f.word = beat_idx_i;
		fill_f.boff = 2'b00;
		// the writeback uses the victim tag with the same set index
		wb_f = fill_f;
		wb_f.line = {victim_tag_i, req_f.line[IDX_W-1:0]};
	end

	// ====================
	// next state
	// ====================

	always_comb begin
		state_d = state_q;
		phase_d = phase_q;
		arr_cmd_o = ARR_NONE;
		arr_word_o = req_f.word;
		arr_wdata_o = cpu_req_i.dat;
		arr_sel_o = cpu_req_i.sel;
		arr_tag_addr_o = cpu_req_i.adr;
		beat_start_o = 1'b0;
		beat_ack_o = 1'b0;
		mem_req_o = '0;
		rsp_load = 1'b0;
		rsp_dat_d = rd_word_i;

		case (state_q)
			IDLE: begin
				// the lookup is issued on the edge that first samples the request
				if (cpu_req && dce_i) begin
					arr_cmd_o = ARR_LOOKUP;
					state_d = LOOKUP;
				end else if (cpu_req) begin
					state_d = BYPASS;
				end
			end
			LOOKUP: begin
				if (hit_i) begin
					// a write hit merges its lanes now, a read hit keeps the word
					if (cpu_req_i.we) begin
						arr_cmd_o = ARR_STORE;
					end else begin
						rsp_load = 1'b1;
					end
					state_d = RESPOND;
				end else begin
					beat_start_o = 1'b1;
					phase_d = 1'b0;
					state_d = victim_dirty_i ? WB_BEAT : FILL_BEAT;
				end
			end
			WB_BEAT: begin
				if (!phase_q) begin
					// fetch the victim word while the bus is idle
					arr_cmd_o = ARR_READ_VICTIM;
					arr_word_o = beat_idx_i;
					phase_d = 1'b1;
				end else begin
					mem_req_o.cyc = 1'b1;
					mem_req_o.stb = 1'b1;
					mem_req_o.we = 1'b1;
					mem_req_o.sel = '1;
					mem_req_o.adr = wb_f;
					mem_req_o.dat = rd_word_i;
					if (mem_rsp_i.ack) begin
						beat_ack_o = 1'b1;
						phase_d = 1'b0;
						if (last_beat_i) begin
							beat_start_o = 1'b1;
							state_d = FILL_BEAT;
						end
					end
				end
			end
			FILL_BEAT: begin
				if (!phase_q) begin
					phase_d = 1'b1;
				end else begin
					mem_req_o.cyc = 1'b1;
					mem_req_o.stb = 1'b1;
					mem_req_o.sel = '1;
					mem_req_o.adr = fill_f;
					if (mem_rsp_i.ack) begin
						arr_cmd_o = ARR_FILL_WORD;
						arr_word_o = beat_idx_i;
						arr_wdata_o = mem_rsp_i.dat;
						arr_sel_o = '1;
						beat_ack_o = 1'b1;
						phase_d = 1'b0;
						// the requested word is caught as it passes by
						if (beat_idx_i == req_f.word) begin
							rsp_load = 1'b1;
							rsp_dat_d = mem_rsp_i.dat;
						end
						if (last_beat_i) begin
							state_d = COMPLETE;
						end
					end
				end
			end
			COMPLETE: begin
				// tag and valid first, then a write miss merges its lanes
				if (!phase_q) begin
					arr_cmd_o = ARR_SET_TAG;
					if (cpu_req_i.we) begin
						phase_d = 1'b1;
					end else begin
						state_d = RESPOND;
					end
				end else begin
					arr_cmd_o = ARR_STORE;
					phase_d = 1'b0;
					state_d = RESPOND;
				end
			end
			BYPASS: begin
				// single word cycle straight through to memory
				mem_req_o = cpu_req_i;
				if (mem_rsp_i.ack) begin
					rsp_load = 1'b1;
					rsp_dat_d = mem_rsp_i.dat;
					state_d = RESPOND;
				end
			end
			RESPOND: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// ====================
	// registers
	// ====================

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= IDLE;
			phase_q <= 1'b0;
		end else begin
			state_q <= state_d;
			phase_q <= phase_d;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_load) begin
			rsp_dat_q <= rsp_dat_d;
		end
	end

	// ack is one cycle wide because RESPOND always returns to IDLE
	assign cpu_rsp_o.ack = (state_q == RESPOND);
	assign cpu_rsp_o.dat = rsp_dat_q;

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
// top level of the data cache with controller, beat counter and way arrays
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
	parameter int SETS = 16,
	localparam int TAG_W = dcache_pkg::LINE_ADR_W - $clog2(SETS)
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire dcache_pkg::wb_req_t cpu_req_i,
	output dcache_pkg::wb_rsp_t cpu_rsp_o,
	output dcache_pkg::wb_req_t mem_req_o,
	input  wire dcache_pkg::wb_rsp_t mem_rsp_i,
	input  wire logic dce_i,
	input  wire logic snoop_v_i,
	input  wire dcache_pkg::addr_t snoop_adr_i,
	input  wire logic inv_all_i
);
	import dcache_pkg::*;

	// controller to arrays
	array_cmd_e arr_cmd;
	logic [WORD_W-1:0] arr_word;
	data_t arr_wdata;
	sel_t arr_sel;
	addr_t arr_tag_addr;

	// arrays to controller, all registered
	logic hit;
	logic victim_dirty;
	logic [TAG_W-1:0] victim_tag;
	data_t rd_word;

	// beat counter handshake
	logic beat_start;
	logic beat_ack;
	logic [WORD_W-1:0] beat_idx;
	logic last_beat;

	dcache_ctrl #(
		.SETS(SETS)
	) u_ctrl (
		.clk(clk),
		.rst(rst),
		.cpu_req_i(cpu_req_i),
		.cpu_rsp_o(cpu_rsp_o),
		.mem_req_o(mem_req_o),
		.mem_rsp_i(mem_rsp_i),
		.dce_i(dce_i),
		.arr_cmd_o(arr_cmd),
		.arr_word_o(arr_word),
		.arr_wdata_o(arr_wdata),
		.arr_sel_o(arr_sel),
		.arr_tag_addr_o(arr_tag_addr),
		.hit_i(hit),
		.victim_dirty_i(victim_dirty),
		.victim_tag_i(victim_tag),
		.rd_word_i(rd_word),
		.beat_start_o(beat_start),
		.beat_ack_o(beat_ack),
		.beat_idx_i(beat_idx),
		.last_beat_i(last_beat)
	);

	// one counter serves both writeback and fill
	line_beat_counter u_beats (
		.clk(clk),
		.rst(rst),
		.start_i(beat_start),
		.ack_i(beat_ack),
		.idx_o(beat_idx),
		.last_o(last_beat)
	);

	// the way number stays inside the arrays, the controller never needs it
	dcache_ways #(
		.SETS(SETS)
	) u_ways (
		.clk(clk),
		.rst(rst),
		.cmd_i(arr_cmd),
		.addr_i(arr_tag_addr),
		.word_i(arr_word),
		.wdata_i(arr_wdata),
		.sel_i(arr_sel),
		.hit_o(hit),
		.hit_way_o(),
		.victim_dirty_o(victim_dirty),
		.victim_tag_o(victim_tag),
		.rd_word_o(rd_word),
		.snoop_v_i(snoop_v_i),
		.snoop_adr_i(snoop_adr_i),
		.inv_all_i(inv_all_i)
	);

endmodule

`default_nettype wire

//--- tests/tb_wb_mem.sv
// wishbone classic memory slave with wait states, backdoor write port and beat counters
`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem #(
	parameter int WORDS = 1024
) (
	input  wire logic clk,
	input  wire logic rst,
	input  wire dcache_pkg::wb_req_t req_i,
	output dcache_pkg::wb_rsp_t rsp_o,
	input  wire logic [1:0] wait_i,
	input  wire logic bd_we_i,
	input  wire dcache_pkg::addr_t bd_adr_i,
	input  wire dcache_pkg::data_t bd_wdat_i,
	output int rd_beats_o,
	output int wr_beats_o
);
	import dcache_pkg::*;

	localparam int IDX_W = $clog2(WORDS);

	data_t mem_q [WORDS];
	logic [1:0] wait_cnt;
	logic [IDX_W-1:0] idx;

	// word index, the address bits above the array simply alias
	assign idx = req_i.adr[IDX_W+1:2];

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			rsp_o <= '0;
			wait_cnt <= '0;
			rd_beats_o <= 0;
			wr_beats_o <= 0;
			// the fill pattern mixes every bit of the byte address
			for (int i = 0; i < WORDS; i++) begin
				mem_q[i] <= (data_t'(i * 4) * 32'h9E37_79B1) ^ 32'h1234_5678;
			end
		end else begin
			// ack lasts exactly one cycle
			rsp_o.ack <= 1'b0;
			// the backdoor write lands on the same edge it is seen
			if (bd_we_i) begin
				mem_q[bd_adr_i[IDX_W+1:2]] <= bd_wdat_i;
			end
			// a beat waits up to three cycles before its ack
			if (req_i.cyc && req_i.stb && !rsp_o.ack) begin
				if (wait_cnt >= wait_i) begin
					wait_cnt <= '0;
					rsp_o.ack <= 1'b1;
					if (req_i.we) begin
						for (int b = 0; b < DATA_W / 8; b++) begin
							if (req_i.sel[b]) begin
								mem_q[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
							end
						end
						wr_beats_o <= wr_beats_o + 1;
					end else begin
						rsp_o.dat <= mem_q[idx];
						rd_beats_o <= rd_beats_o + 1;
					end
				end else begin
					wait_cnt <= wait_cnt + 2'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_dcache.sv
// data cache testbench with clock, reset, LFSR stimulus, shadow memory, directed tests and checks
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
	import dcache_pkg::*;

	localparam int MEM_WORDS = 1024;
	// every access is charged as a worst case miss and the sum is doubled
	localparam int ACCESSES = 24;
	localparam int MISS_CYCLES = 8 * 4 + 4;
	localparam int CYCLE_LIMIT = 2 * ACCESSES * MISS_CYCLES + 100;

	logic clk;
	logic rst;
	wb_req_t cpu_req;
	wb_rsp_t cpu_rsp;
	wb_req_t mem_req;
	wb_rsp_t mem_rsp;
	logic dce;
	logic snoop_v;
	addr_t snoop_adr;
	logic inv_all;
	logic [1:0] mem_wait = 2'd0;
	logic bd_we;
	addr_t bd_adr;
	data_t bd_wdat;
	int rd_beats;
	int wr_beats;

	// separate LFSR states keep data and wait states independent of process order
	logic [31:0] data_lfsr = 32'd83910;
	logic [31:0] wait_lfsr = 32'd83910;
	data_t shadow [MEM_WORDS];
	int data_errors;
	int count_errors;
	int cycle_count = 0;

	dcache_top #(
		.SETS(16)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.cpu_req_i(cpu_req),
		.cpu_rsp_o(cpu_rsp),
		.mem_req_o(mem_req),
		.mem_rsp_i(mem_rsp),
		.dce_i(dce),
		.snoop_v_i(snoop_v),
		.snoop_adr_i(snoop_adr),
		.inv_all_i(inv_all)
	);

	tb_wb_mem #(
		.WORDS(MEM_WORDS)
	) u_mem (
		.clk(clk),
		.rst(rst),
		.req_i(mem_req),
		.rsp_o(mem_rsp),
		.wait_i(mem_wait),
		.bd_we_i(bd_we),
		.bd_adr_i(bd_adr),
		.bd_wdat_i(bd_wdat),
		.rd_beats_o(rd_beats),
		.wr_beats_o(wr_beats)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ====================
	// helpers
	// ====================

	// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one LFSR step for every bit taken
	task automatic take_bits(inout logic [31:0] state, input int n, output data_t bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_step(state);
			bits = {bits[DATA_W-2:0], state[0]};
		end
	endtask

	function automatic int word_index(input addr_t adr);
		return int'(adr[11:2]);
	endfunction

	// a set select bit takes the new byte, a clear one keeps the old byte
	function automatic data_t merge_lanes(input data_t old, input data_t dat, input sel_t sel);
		data_t res;
		for (int b = 0; b < 4; b++) begin
			res[8*b +: 8] = sel[b] ? dat[8*b +: 8] : old[8*b +: 8];
		end
		return res;
	endfunction

	task automatic check_data(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			data_errors++;
			$display("FAILED at %0t: %s, got %08h expected %08h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			count_errors++;
			$display("FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// wait states change every falling edge, the memory picks them up per beat
	always @(negedge clk) begin
		data_t wait_bits;
		take_bits(wait_lfsr, 2, wait_bits);
		mem_wait <= wait_bits[1:0];
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ====================
	// bus tasks
	// ====================

	// one classic cycle, held until ack, cycles counts falling edges up to ack
	task automatic cpu_access(input logic we, input addr_t adr, input data_t wdat,
			input sel_t sel, output data_t rdat, output int cycles);
		@(negedge clk);
		cpu_req.cyc = 1'b1;
		cpu_req.stb = 1'b1;
		cpu_req.we = we;
		cpu_req.sel = sel;
		cpu_req.adr = adr;
		cpu_req.dat = wdat;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!cpu_rsp.ack);
		rdat = cpu_rsp.dat;
		cpu_req = '0;
	endtask

	task automatic read_word(input addr_t adr, output int cycles);
		data_t got;
		cpu_access(1'b0, adr, '0, '1, got, cycles);
		check_data(got, shadow[word_index(adr)], $sformatf("read of %08h", adr));
	endtask

	task automatic write_word(input addr_t adr, input data_t dat, input sel_t sel);
		data_t ignored_rdat;
		int ignored_cycles;
		cpu_access(1'b1, adr, dat, sel, ignored_rdat, ignored_cycles);
		shadow[word_index(adr)] = merge_lanes(shadow[word_index(adr)], dat, sel);
	endtask

	task automatic backdoor_write(input addr_t adr, input data_t dat);
		@(negedge clk);
		bd_we = 1'b1;
		bd_adr = adr;
		bd_wdat = dat;
		@(negedge clk);
		bd_we = 1'b0;
		shadow[word_index(adr)] = dat;
	endtask

	task automatic pulse_snoop(input addr_t adr);
		@(negedge clk);
		snoop_v = 1'b1;
		snoop_adr = adr;
		@(negedge clk);
		snoop_v = 1'b0;
	endtask

	task automatic pulse_inv_all();
		@(negedge clk);
		inv_all = 1'b1;
		@(negedge clk);
		inv_all = 1'b0;
	endtask

	// ====================
	// directed tests
	// ====================

	task automatic read_miss_fills_line();
		int rd0;
		int cycles;
		rd0 = rd_beats;
		read_word(32'h0000_0104, cycles);
		check_count(rd_beats - rd0, 4, "read miss beats");
		// the other words of the line come from the arrays in two cycles
		for (int w = 0; w < 4; w++) begin
			if (w != 1) begin
				rd0 = rd_beats;
				read_word(32'h0000_0100 + addr_t'(4 * w), cycles);
				check_count(rd_beats - rd0, 0, "memory beats on read hit");
				check_count(cycles, 2, "read hit latency");
			end
		end
	endtask

	task automatic write_hit_merges_lanes();
		int rd0;
		int wr0;
		int cycles;
		data_t dat;
		rd0 = rd_beats;
		wr0 = wr_beats;
		take_bits(data_lfsr, 32, dat);
		write_word(32'h0000_0108, dat, 4'b0101);
		take_bits(data_lfsr, 32, dat);
		write_word(32'h0000_0108, dat, 4'b1000);
		read_word(32'h0000_0108, cycles);
		check_count(wr_beats - wr0, 0, "memory writes on write hit");
		check_count(rd_beats - rd0, 0, "memory reads on write hit");
	endtask

	// lines 0x050, 0x150 and 0x250 all map to set 5
	task automatic set_conflict_evicts();
		int rd0;
		int wr0;
		int cycles;
		data_t dat;
		take_bits(data_lfsr, 32, dat);
		write_word(32'h0000_0050, dat, 4'b1111);
		take_bits(data_lfsr, 32, dat);
		write_word(32'h0000_0154, dat, 4'b0110);
		rd0 = rd_beats;
		wr0 = wr_beats;
		// both ways are dirty, round robin names way 0 which holds 0x050
		take_bits(data_lfsr, 32, dat);
		write_word(32'h0000_0258, dat, 4'b1111);
		check_count(wr_beats - wr0, 4, "victim writeback beats");
		check_count(rd_beats - rd0, 4, "refill beats after writeback");
		for (int w = 0; w < 4; w++) begin
			check_data(u_mem.mem_q[word_index(32'h0000_0050 + addr_t'(4 * w))],
				shadow[word_index(32'h0000_0050 + addr_t'(4 * w))], "written back word");
		end
		read_word(32'h0000_0050, cycles);
		read_word(32'h0000_0154, cycles);
		read_word(32'h0000_0258, cycles);
	endtask

	task automatic snoop_forces_refetch();
		int rd0;
		int cycles;
		data_t dat;
		read_word(32'h0000_0304, cycles);
		rd0 = rd_beats;
		read_word(32'h0000_0304, cycles);
		check_count(rd_beats - rd0, 0, "memory reads on hit before snoop");
		take_bits(data_lfsr, 32, dat);
		backdoor_write(32'h0000_0304, dat);
		// any address inside the line drops it
		pulse_snoop(32'h0000_030C);
		rd0 = rd_beats;
		read_word(32'h0000_0304, cycles);
		check_count(rd_beats - rd0, 4, "refetch beats after snoop");
	endtask

	task automatic bypass_goes_to_memory();
		int rd0;
		int wr0;
		int cycles;
		data_t dat;
		@(negedge clk);
		dce = 1'b0;
		rd0 = rd_beats;
		wr0 = wr_beats;
		read_word(32'h0000_0400, cycles);
		check_count(rd_beats - rd0, 1, "memory reads on bypass read");
		check_count(wr_beats - wr0, 0, "memory writes on bypass read");
		take_bits(data_lfsr, 32, dat);
		write_word(32'h0000_0404, dat, 4'b0011);
		check_count(wr_beats - wr0, 1, "memory writes on bypass write");
		check_count(rd_beats - rd0, 1, "memory reads on bypass write");
		check_data(u_mem.mem_q[word_index(32'h0000_0404)], shadow[word_index(32'h0000_0404)],
			"bypass write in memory");
		@(negedge clk);
		dce = 1'b1;
	endtask

	task automatic inv_all_forces_refetch();
		int rd0;
		int cycles;
		rd0 = rd_beats;
		read_word(32'h0000_0308, cycles);
		check_count(rd_beats - rd0, 0, "memory reads on hit before invalidate");
		pulse_inv_all();
		rd0 = rd_beats;
		read_word(32'h0000_0308, cycles);
		check_count(rd_beats - rd0, 4, "refetch beats after invalidate");
	endtask

	// ====================
	// sequence
	// ====================

	initial begin
		rst = 1'b1;
		cpu_req = '0;
		dce = 1'b1;
		snoop_v = 1'b0;
		snoop_adr = '0;
		inv_all = 1'b0;
		bd_we = 1'b0;
		bd_adr = '0;
		bd_wdat = '0;
		data_errors = 0;
		count_errors = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// the shadow starts as the memory image loaded during reset
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow[i] = u_mem.mem_q[i];
		end
		read_miss_fills_line();
		write_hit_merges_lanes();
		set_conflict_evicts();
		snoop_forces_refetch();
		bypass_goes_to_memory();
		inv_all_forces_refetch();
		$display("summary: %0d data mismatches, %0d count mismatches", data_errors, count_errors);
		if (data_errors + count_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
verilog/dcache_pkg.sv
verilog/line_beat_counter.sv
verilog/dcache_ways.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tests/tb_wb_mem.sv
tests/tb_dcache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the data cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f build.f --top-module tb_dcache -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/Vtb_dcache)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -q "^TESTBENCH PASSED$"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
